// File: sim.f
+incdir+common
+incdir+dv
common/fsq_pkg.sv
fsq_queue/fsq_pointers.sv
fsq_queue/fsq_stream_ram.sv
hw/btb_entry_gen.sv
hw/fsq_commit.sv
hw/fsq_top.sv
dv/fsq_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = fsq_tb
FILELIST = sim.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log

SRCS = $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS = $(wildcard common/*.svh dv/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/fsq_tb_model.svh
`ifndef FSQ_TB_MODEL_SVH
`define FSQ_TB_MODEL_SVH

// sequence numbers grow without bound, slot and wrap bit are derived from them
fsq_pkg::prediction_t m_store [`FSQ_SIZE];
fsq_pkg::wb_info_t m_wb [`FSQ_SIZE];
logic m_mispred [`FSQ_SIZE];
int m_tail;
int m_search;
int m_head;
int m_cnt;

// registered outputs expected after the coming edge
logic exp_squash_en;
logic exp_upd_en;
fsq_pkg::squash_t exp_squash;
fsq_pkg::update_t exp_upd;

function automatic logic [`FSQ_WIDTH-1:0] slot_of(input int seq);
    return `FSQ_WIDTH'(seq % `FSQ_SIZE);
endfunction

function automatic fsq_pkg::fsq_idx_t seq_to_idx(input int seq);
    fsq_pkg::fsq_idx_t r;
    r.idx = slot_of(seq);
    r.dir = 1'((seq / `FSQ_SIZE) % 2);
    return r;
endfunction

// offset of the last instruction that retires with the block
function automatic int block_len(input int seq);
    logic [`FSQ_WIDTH-1:0] s;
    s = slot_of(seq);
    if (m_mispred[s]) begin
        return int'(m_wb[s].offset);
    end
    return int'(m_store[s].stream.size);
endfunction

function automatic fsq_pkg::btb_entry_t rebuild_entry(input fsq_pkg::btb_entry_t old,
                                                     input fsq_pkg::wb_info_t wb);
    fsq_pkg::btb_entry_t e;
    fsq_pkg::btb_slot_t s;
    logic cond_hit;
    logic tail_hit;
    e = old;
    e.valid = 1'b1;
    s.valid = 1'b1;
    s.offset = wb.offset;
    s.br_type = wb.br_type;
    s.target = wb.target;
    cond_hit = old.cond_slot.valid && (old.cond_slot.offset == wb.offset);
    tail_hit = old.tail_slot.valid && (old.tail_slot.offset == wb.offset);
    if (wb.br_type != fsq_pkg::br_cond) begin
        e.tail_slot = s;
    end else if (cond_hit) begin
        e.cond_slot = s;
        if (!wb.taken) begin
            e.cond_slot.target = old.cond_slot.target;
        end
    end else if (tail_hit) begin
        e.tail_slot = s;
        if (!wb.taken) begin
            e.tail_slot.target = old.tail_slot.target;
        end
    end else if (!old.cond_slot.valid) begin
        e.cond_slot = s;
    end else if (!old.tail_slot.valid) begin
        e.tail_slot = s;
    end else if (old.tail_slot.offset >= old.cond_slot.offset) begin
        if (wb.offset < old.tail_slot.offset) begin
            e.tail_slot = s;
        end
    end else if (wb.offset < old.cond_slot.offset) begin
        e.cond_slot = s;
    end
    return e;
endfunction

function automatic fsq_pkg::update_t expected_update(input logic [`FSQ_WIDTH-1:0] s);
    fsq_pkg::update_t u;
    u.start_addr = m_store[s].stream.start_addr;
    u.mispred = m_mispred[s];
    if (m_mispred[s]) begin
        u.target = m_wb[s].target;
        u.taken = m_wb[s].taken;
        u.btb_entry = rebuild_entry(m_store[s].btb_entry, m_wb[s]);
    end else begin
        u.target = m_store[s].stream.target;
        u.taken = m_store[s].stream.taken;
        u.btb_entry = m_store[s].btb_entry;
    end
    return u;
endfunction

task automatic model_reset();
    for (int i = 0; i < `FSQ_SIZE; i++) begin
        m_store[i] = '0;
        m_wb[i] = '0;
        m_mispred[i] = 1'b0;
    end
    m_tail = 0;
    m_search = 0;
    m_head = 0;
    m_cnt = 0;
    exp_squash_en = 1'b0;
    exp_upd_en = 1'b0;
endtask

// one rising edge of the queue
task automatic model_clock(input logic pe, input fsq_pkg::prediction_t p, input logic fr,
                           input logic re, input fsq_pkg::backend_redirect_t r,
                           input int rseq, input int cn);
    int len;
    logic adv;
    logic full;
    logic fire;
    logic [`FSQ_WIDTH-1:0] s;
    len = block_len(m_head);
    adv = m_cnt > len;
    full = (m_tail - m_head) == `FSQ_SIZE;
    fire = (m_search != m_tail) && !re && fr;
    exp_upd_en = adv;
    if (adv) begin
        exp_upd = expected_update(slot_of(m_head));
        m_cnt = m_cnt - len - 1;
        m_head++;
    end
    m_cnt = m_cnt + cn;
    exp_squash_en = re;
    if (re) begin
        exp_squash.idx = r.idx;
        exp_squash.target = r.target;
        exp_squash.br_type = r.br_type;
        s = r.idx.idx;
        m_wb[s].offset = r.offset;
        m_wb[s].taken = r.taken;
        m_wb[s].br_type = r.br_type;
        m_wb[s].target = r.target;
        m_mispred[s] = r.mispred;
        m_tail = rseq + 1;
        m_search = rseq + 1;
    end else begin
        if (pe && !full) begin
            s = slot_of(m_tail);
            m_store[s] = p;
            m_mispred[s] = 1'b0;
            m_tail++;
        end
        if (fire) begin
            m_search++;
        end
    end
endtask

`endif

// File: dv/fsq_tb.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_tb;
    localparam int PHASE_CYCLES = 600;
    localparam int TOTAL_CYCLES = 4 * PHASE_CYCLES + 4;

    logic clk;
    logic rst;
    logic pred_en;
    fsq_pkg::prediction_t pred;
    logic fetch_ready;
    logic redir_en;
    fsq_pkg::backend_redirect_t redir;
    logic [2:0] commit_num;
    logic pred_stall;
    logic fetch_en;
    fsq_pkg::fetch_req_t fetch;
    logic squash_en;
    fsq_pkg::squash_t squash;
    logic upd_en;
    fsq_pkg::update_t upd;

    int checks;
    int errors;
    int redir_seq;
    bit allow_enq;
    bit allow_redir;
    bit allow_commit;

    `include "fsq_tb_model.svh"

    fsq_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .pred_en     (pred_en),
        .pred        (pred),
        .fetch_ready (fetch_ready),
        .redir_en    (redir_en),
        .redir       (redir),
        .commit_num  (commit_num),
        .pred_stall  (pred_stall),
        .fetch_en    (fetch_en),
        .fetch       (fetch),
        .squash_en   (squash_en),
        .squash      (squash),
        .upd_en      (upd_en),
        .upd         (upd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * 8 * 4);
        $display("watchdog expired at %0t, the run did not finish in time", $time);
        $display("Test failures found");
        $finish;
    end

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_fetch(input fsq_pkg::fetch_req_t got, input fsq_pkg::fetch_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: fetch is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_squash(input fsq_pkg::squash_t got, input fsq_pkg::squash_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: squash is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_update(input fsq_pkg::update_t got, input fsq_pkg::update_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: update is %h, expected %h", $time, got, exp);
        end
    endtask

    function automatic fsq_pkg::br_type_e random_type();
        if ($urandom_range(1, 0) == 0) begin
            return fsq_pkg::br_cond;
        end
        return fsq_pkg::br_type_e'(3'($urandom_range(4, 0)));
    endfunction

    function automatic fsq_pkg::btb_slot_t random_slot();
        fsq_pkg::btb_slot_t s;
        s.valid = 1'($urandom_range(1, 0));
        s.offset = `PRED_WIDTH'($urandom_range(7, 0));
        s.br_type = random_type();
        s.target = $urandom;
        return s;
    endfunction

    task automatic drive_inputs();
        int avail;
        logic [`FSQ_WIDTH-1:0] s;
        pred_en = allow_enq && ($urandom_range(3, 0) != 0);
        pred.stream.start_addr = $urandom;
        pred.stream.target = $urandom;
        pred.stream.size = `PRED_WIDTH'($urandom_range(7, 0));
        pred.stream.taken = 1'($urandom_range(1, 0));
        pred.btb_entry.valid = 1'($urandom_range(1, 0));
        pred.btb_entry.cond_slot = random_slot();
        pred.btb_entry.tail_slot = random_slot();
        fetch_ready = ($urandom_range(2, 0) != 0);
        redir_en = 1'b0;
        // only blocks behind the commit head can be redirected
        if (allow_redir && (m_search - m_head) >= 2 && $urandom_range(9, 0) == 0) begin
            redir_seq = m_head + 1 + int'($urandom_range(m_search - m_head - 2, 0));
            s = slot_of(redir_seq);
            redir_en = 1'b1;
            redir.idx = seq_to_idx(redir_seq);
            case ($urandom_range(3, 0))
                0: redir.offset = m_store[s].btb_entry.cond_slot.offset;
                1: redir.offset = m_store[s].btb_entry.tail_slot.offset;
                default: redir.offset = `PRED_WIDTH'($urandom_range(7, 0));
            endcase
            redir.mispred = ($urandom_range(3, 0) != 0);
            redir.taken = 1'($urandom_range(1, 0));
            redir.br_type = random_type();
            redir.target = $urandom;
        end
        // backend commits fetched instructions of the head block only
        avail = 0;
        if (allow_commit && m_head < m_search) begin
            avail = block_len(m_head) + 1 - m_cnt;
        end
        if (avail > 4) begin
            avail = 4;
        end
        commit_num = 3'($urandom_range(avail, 0));
    endtask

    task automatic check_cycle();
        fsq_pkg::fetch_req_t exp_fetch;
        logic exp_fetch_en;
        compare_flag(squash_en, exp_squash_en, "squash_en");
        if (exp_squash_en) begin
            compare_squash(squash, exp_squash);
        end
        compare_flag(upd_en, exp_upd_en, "upd_en");
        if (exp_upd_en) begin
            compare_update(upd, exp_upd);
        end
        compare_flag(pred_stall, (m_tail - m_head) == `FSQ_SIZE, "pred_stall");
        exp_fetch_en = (m_search != m_tail) && !redir_en;
        compare_flag(fetch_en, exp_fetch_en, "fetch_en");
        if (exp_fetch_en) begin
            exp_fetch.idx = seq_to_idx(m_search);
            exp_fetch.stream = m_store[slot_of(m_search)].stream;
            compare_fetch(fetch, exp_fetch);
        end
        model_clock(pred_en, pred, fetch_ready, redir_en, redir, redir_seq, int'(commit_num));
    endtask

    task automatic run_phase(input string name, input bit enq, input bit rd, input bit cm,
                             input int cycles);
        int checks_before;
        int errors_before;
        checks_before = checks;
        errors_before = errors;
        allow_enq = enq;
        allow_redir = rd;
        allow_commit = cm;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            check_cycle();
        end
        $display("%-12s %0d checks, %0d errors", name, checks - checks_before,
                 errors - errors_before);
    endtask

    initial begin
        void'($urandom(32'hb3fe_d9bf));
        checks = 0;
        errors = 0;
        redir_seq = 0;
        rst = 1'b1;
        pred_en = 1'b0;
        pred = '0;
        fetch_ready = 1'b0;
        redir_en = 1'b0;
        redir = '0;
        commit_num = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        run_phase("reset", 1'b0, 1'b0, 1'b0, 1);
        run_phase("fetch_order", 1'b1, 1'b0, 1'b1, PHASE_CYCLES);
        run_phase("redirect", 1'b1, 1'b1, 1'b1, PHASE_CYCLES);
        run_phase("commit", 1'b1, 1'b0, 1'b1, PHASE_CYCLES);
        run_phase("mispredict", 1'b1, 1'b1, 1'b1, PHASE_CYCLES);
        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: hw/fsq_top.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pred_en,
    input  fsq_pkg::prediction_t       pred,
    input  logic                       fetch_ready,
    input  logic                       redir_en,
    input  fsq_pkg::backend_redirect_t redir,
    input  logic [2:0]                 commit_num,
    output logic                       pred_stall,
    output logic                       fetch_en,
    output fsq_pkg::fetch_req_t        fetch,
    output logic                       squash_en,
    output fsq_pkg::squash_t           squash,
    output logic                       upd_en,
    output fsq_pkg::update_t           upd
);
    logic wr_en;
    logic commit_adv;
    fsq_pkg::fsq_idx_t wr_idx;
    fsq_pkg::fsq_idx_t search_idx;
    fsq_pkg::fsq_idx_t commit_idx;
    fsq_pkg::fetch_stream_t search_stream;
    fsq_pkg::fetch_stream_t commit_stream;
    fsq_pkg::btb_entry_t commit_entry;

    fsq_pointers u_pointers (
        .clk         (clk),
        .rst         (rst),
        .pred_en     (pred_en),
        .fetch_ready (fetch_ready),
        .redir_en    (redir_en),
        .redir_idx   (redir.idx),
        .commit_adv  (commit_adv),
        .pred_stall  (pred_stall),
        .fetch_en    (fetch_en),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .search_idx  (search_idx),
        .commit_idx  (commit_idx)
    );

    fsq_stream_ram u_stream_ram (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (pred),
        .search_idx    (search_idx),
        .commit_idx    (commit_idx),
        .search_stream (search_stream),
        .commit_stream (commit_stream),
        .commit_entry  (commit_entry)
    );

    // the cache sees the block at the search head directly
    assign fetch.idx = search_idx;
    assign fetch.stream = search_stream;

    fsq_commit u_commit (
        .clk           (clk),
        .rst           (rst),
        .redir_en      (redir_en),
        .redir         (redir),
        .commit_num    (commit_num),
        .commit_idx    (commit_idx),
        .commit_stream (commit_stream),
        .commit_entry  (commit_entry),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .commit_adv    (commit_adv),
        .squash_en     (squash_en),
        .squash        (squash),
        .upd_en        (upd_en),
        .upd           (upd)
    );

endmodule

// File: hw/fsq_commit.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_commit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       redir_en,
    input  fsq_pkg::backend_redirect_t redir,
    input  logic [2:0]                 commit_num,
    input  fsq_pkg::fsq_idx_t          commit_idx,
    input  fsq_pkg::fetch_stream_t     commit_stream,
    input  fsq_pkg::btb_entry_t        commit_entry,
    input  logic                       wr_en,
    input  fsq_pkg::fsq_idx_t          wr_idx,
    output logic                       commit_adv,
    output logic                       squash_en,
    output fsq_pkg::squash_t           squash,
    output logic                       upd_en,
    output fsq_pkg::update_t           upd
);
    // enough for a full queue of full blocks plus one cycle of commits
    localparam int CNT_W = $clog2(`FSQ_SIZE << `PRED_WIDTH) + 1;

    fsq_pkg::wb_info_t wb_table [`FSQ_SIZE];
    fsq_pkg::wb_info_t redir_wb;
    fsq_pkg::wb_info_t commit_wb;
    fsq_pkg::btb_entry_t new_entry;
    logic [`FSQ_SIZE-1:0] mispred;
    logic pred_error;
    logic [`PRED_WIDTH-1:0] commit_len;
    logic [CNT_W-1:0] commit_cnt;
    logic [CNT_W-1:0] retire_num;

    always_comb begin
        redir_wb.offset = redir.offset;
        redir_wb.taken = redir.taken;
        redir_wb.br_type = redir.br_type;
        redir_wb.target = redir.target;
    end

    always_ff @(posedge clk) begin
        if (redir_en) begin
            wb_table[redir.idx.idx] <= redir_wb;
        end
    end

    // a fresh stream in a slot forgets the old misprediction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispred <= '0;
        end else begin
            if (wr_en) begin
                mispred[wr_idx.idx] <= 1'b0;
            end
            if (redir_en) begin
                mispred[redir.idx.idx] <= redir.mispred;
            end
        end
    end

    assign commit_wb = wb_table[commit_idx.idx];
    assign pred_error = mispred[commit_idx.idx];

    // a mispredicted block ends at the redirecting instruction
    assign commit_len = pred_error ? commit_wb.offset : commit_stream.size;
    assign commit_adv = commit_cnt > CNT_W'(commit_len);
    assign retire_num = commit_adv ? CNT_W'(commit_len) + 1'b1 : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_cnt <= '0;
        end else begin
            commit_cnt <= commit_cnt + CNT_W'(commit_num) - retire_num;
        end
    end

    btb_entry_gen u_btb_entry_gen (
        .old_entry  (commit_entry),
        .pred_error (pred_error),
        .wb         (commit_wb),
        .new_entry  (new_entry)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd_en <= 1'b0;
            squash_en <= 1'b0;
        end else begin
            upd_en <= commit_adv;
            squash_en <= redir_en;
        end
    end

    always_ff @(posedge clk) begin
        upd.start_addr <= commit_stream.start_addr;
        upd.target <= pred_error ? commit_wb.target : commit_stream.target;
        upd.taken <= pred_error ? commit_wb.taken : commit_stream.taken;
        upd.mispred <= pred_error;
        upd.btb_entry <= new_entry;
        squash.idx <= redir.idx;
        squash.target <= redir.target;
        squash.br_type <= redir.br_type;
    end

endmodule

// File: hw/btb_entry_gen.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module btb_entry_gen (
    input  fsq_pkg::btb_entry_t old_entry,
    input  logic                pred_error,
    input  fsq_pkg::wb_info_t   wb,
    output fsq_pkg::btb_entry_t new_entry
);
    // bit 0 is the conditional slot, bit 1 the tail slot
    logic [`SLOT_NUM-1:0] hit;
    logic [`SLOT_NUM-1:0] free;
    logic [`SLOT_NUM-1:0] sel;
    logic tail_larger;
    fsq_pkg::btb_slot_t new_slot;

    assign hit[0] = old_entry.cond_slot.valid && (old_entry.cond_slot.offset == wb.offset);
    assign hit[1] = old_entry.tail_slot.valid && (old_entry.tail_slot.offset == wb.offset);
    assign free[0] = ~old_entry.cond_slot.valid;
    assign free[1] = ~old_entry.tail_slot.valid;

    // equal offsets evict the tail slot
    assign tail_larger = old_entry.tail_slot.offset >= old_entry.cond_slot.offset;

    // slot choice for a conditional branch
    always_comb begin
        sel = '0;
        if (|hit) begin
            sel = hit[0] ? 2'b01 : 2'b10;
        end else if (free[0]) begin
            sel = 2'b01;
        end else if (free[1]) begin
            sel = 2'b10;
        end else if (tail_larger) begin
            if (wb.offset < old_entry.tail_slot.offset) begin
                sel = 2'b10;
            end
        end else if (wb.offset < old_entry.cond_slot.offset) begin
            sel = 2'b01;
        end
    end

    always_comb begin
        new_slot.valid = 1'b1;
        new_slot.offset = wb.offset;
        new_slot.br_type = wb.br_type;
        new_slot.target = wb.target;
    end

    always_comb begin
        new_entry = old_entry;
        if (pred_error) begin
            new_entry.valid = 1'b1;
            if (wb.br_type != fsq_pkg::br_cond) begin
                new_entry.tail_slot = new_slot;
            end else begin
                if (sel[0]) begin
                    new_entry.cond_slot = new_slot;
                end
                if (sel[1]) begin
                    new_entry.tail_slot = new_slot;
                end
                // not-taken on a known branch keeps the learned target
                if (hit[0] && sel[0] && !wb.taken) begin
                    new_entry.cond_slot.target = old_entry.cond_slot.target;
                end
                if (hit[1] && sel[1] && !wb.taken) begin
                    new_entry.tail_slot.target = old_entry.tail_slot.target;
                end
            end
        end
    end

endmodule

// File: fsq_queue/fsq_stream_ram.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_stream_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  fsq_pkg::fsq_idx_t      wr_idx,
    input  fsq_pkg::prediction_t   wr_data,
    input  fsq_pkg::fsq_idx_t      search_idx,
    input  fsq_pkg::fsq_idx_t      commit_idx,
    output fsq_pkg::fetch_stream_t search_stream,
    output fsq_pkg::fetch_stream_t commit_stream,
    output fsq_pkg::btb_entry_t    commit_entry
);
    fsq_pkg::fetch_stream_t streams [`FSQ_SIZE];
    fsq_pkg::btb_entry_t entries [`FSQ_SIZE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `FSQ_SIZE; i++) begin
                streams[i] <= '0;
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            streams[wr_idx.idx] <= wr_data.stream;
            entries[wr_idx.idx] <= wr_data.btb_entry;
        end
    end

    // fetch port
    assign search_stream = streams[search_idx.idx];

    // commit port, stream plus the entry the predictor used
    assign commit_stream = streams[commit_idx.idx];
    assign commit_entry = entries[commit_idx.idx];

endmodule

// File: fsq_queue/fsq_pointers.sv
`timescale 1ns/1ps
`include "fsq_defines.svh"

module fsq_pointers (
    input  logic              clk,
    input  logic              rst,
    input  logic              pred_en,
    input  logic              fetch_ready,
    input  logic              redir_en,
    input  fsq_pkg::fsq_idx_t redir_idx,
    input  logic              commit_adv,
    output logic              pred_stall,
    output logic              fetch_en,
    output logic              wr_en,
    output fsq_pkg::fsq_idx_t wr_idx,
    output fsq_pkg::fsq_idx_t search_idx,
    output fsq_pkg::fsq_idx_t commit_idx
);
    fsq_pkg::fsq_idx_t tail;
    fsq_pkg::fsq_idx_t search_head;
    fsq_pkg::fsq_idx_t commit_head;
    fsq_pkg::fsq_idx_t tail_n1;
    fsq_pkg::fsq_idx_t search_n1;
    fsq_pkg::fsq_idx_t commit_n1;
    fsq_pkg::fsq_idx_t redir_n1;
    logic full;
    logic fetch_fire;

    // next slot, flipping the wrap bit when the index rolls over
    function automatic fsq_pkg::fsq_idx_t idx_inc(input fsq_pkg::fsq_idx_t p);
        fsq_pkg::fsq_idx_t r;
        if (p.idx == `FSQ_WIDTH'(`FSQ_SIZE - 1)) begin
            r.idx = '0;
            r.dir = ~p.dir;
        end else begin
            r.idx = p.idx + 1'b1;
            r.dir = p.dir;
        end
        return r;
    endfunction

    assign tail_n1 = idx_inc(tail);
    assign search_n1 = idx_inc(search_head);
    assign commit_n1 = idx_inc(commit_head);
    // resume right after the redirected block
    assign redir_n1 = idx_inc(redir_idx);

    // same slot, different lap
    assign full = (tail.idx == commit_head.idx) && (tail.dir != commit_head.dir);
    assign pred_stall = full;

    // redirect wins over an enqueue in the same cycle
    assign wr_en = pred_en & ~full & ~redir_en;
    assign wr_idx = tail;

    assign fetch_en = (search_head != tail) & ~redir_en;
    assign fetch_fire = fetch_en & fetch_ready;
    assign search_idx = search_head;
    assign commit_idx = commit_head;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
            search_head <= '0;
        end else if (redir_en) begin
            tail <= redir_n1;
            search_head <= redir_n1;
        end else begin
            if (wr_en) begin
                tail <= tail_n1;
            end
            if (fetch_fire) begin
                search_head <= search_n1;
            end
        end
    end

    // commit head only moves forward, one block at most
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_head <= '0;
        end else if (commit_adv) begin
            commit_head <= commit_n1;
        end
    end

endmodule

// File: common/fsq_pkg.sv
`include "fsq_defines.svh"

package fsq_pkg;

    typedef enum logic [2:0] {
        br_cond,
        br_direct,
        br_indirect,
        br_call,
        br_ret
    } br_type_e;

    // dir is the wrap bit
    typedef struct packed {
        logic dir;
        logic [`FSQ_WIDTH-1:0] idx;
    } fsq_idx_t;

    // size is the offset of the last instruction in the block
    typedef struct packed {
        logic [`VADDR_SIZE-1:0] start_addr;
        logic [`VADDR_SIZE-1:0] target;
        logic [`PRED_WIDTH-1:0] size;
        logic taken;
    } fetch_stream_t;

    typedef struct packed {
        logic valid;
        logic [`PRED_WIDTH-1:0] offset;
        br_type_e br_type;
        logic [`VADDR_SIZE-1:0] target;
    } btb_slot_t;

    typedef struct packed {
        logic valid;
        btb_slot_t cond_slot;
        btb_slot_t tail_slot;
    } btb_entry_t;

    typedef struct packed {
        fetch_stream_t stream;
        btb_entry_t btb_entry;
    } prediction_t;

    typedef struct packed {
        fsq_idx_t idx;
        fetch_stream_t stream;
    } fetch_req_t;

    typedef struct packed {
        fsq_idx_t idx;
        logic [`PRED_WIDTH-1:0] offset;
        logic mispred;
        logic taken;
        br_type_e br_type;
        logic [`VADDR_SIZE-1:0] target;
    } backend_redirect_t;

    typedef struct packed {
        fsq_idx_t idx;
        logic [`VADDR_SIZE-1:0] target;
        br_type_e br_type;
    } squash_t;

    // resolved branch as seen by the backend
    typedef struct packed {
        logic [`PRED_WIDTH-1:0] offset;
        logic taken;
        br_type_e br_type;
        logic [`VADDR_SIZE-1:0] target;
    } wb_info_t;

    typedef struct packed {
        logic [`VADDR_SIZE-1:0] start_addr;
        logic [`VADDR_SIZE-1:0] target;
        logic taken;
        logic mispred;
        btb_entry_t btb_entry;
    } update_t;

endpackage

// File: common/fsq_defines.svh
`ifndef FSQ_DEFINES_SVH
`define FSQ_DEFINES_SVH

// queue depth and the index width that addresses it
`define FSQ_SIZE 8
`define FSQ_WIDTH 3

// virtual address width
`define VADDR_SIZE 32

// instruction offset inside a fetch block, 8 instructions per block
`define PRED_WIDTH 3

// instruction offset to byte offset
`define INST_OFFSET 2

// one conditional slot plus one tail slot per btb entry
`define SLOT_NUM 2

`endif
